// File: bench/dcache_patterns.txt
// kind (delay<<8 | op), address, write data, expected read data.
// op 0 read hit, 1 read miss, 2 write, 3 sideband read, 4 sideband write.
0001 00001040 00000000 ffffefbf
0000 00001044 00000000 00001040
0000 00001078 00000000 ffffef87
0002 0000104c 12345678 00000000
0000 0000104c 00000000 12345678
0000 00001048 00000000 ffffefb7
0002 00002084 cafef00d 00000000
0001 00002084 00000000 cafef00d
0000 00002080 00000000 ffffdf7f
0001 00005040 00000000 ffffafbf
0001 00001040 00000000 ffffefbf
0001 00005044 00000000 00005040
0001 0000104c 00000000 12345678
0303 81000010 00000000 a5000010
0204 82000020 55aa55aa 00000000
0003 83000030 00000000 deaddead
0002 00003000 11110000 00000000
0002 00003008 22220000 00000000
0002 00003010 0000aaaa 00000000
0002 00003018 33330000 00000000
0002 00003024 44440000 00000000
0002 0000302c 55550000 00000000
0001 00003010 00000000 0000aaaa
0000 00003024 00000000 44440000
ffffffff 00000000 00000000 00000000

// File: list.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_timer.sv
verilog/dcache_store.sv
verilog/dcache_bus_req.sv
verilog/dcache_top.sv
bench/dcache_assert.sv
bench/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dcache_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/dcache_tb.sv
// Pattern-driven testbench for the data cache. Runs from the project root so the pattern path resolves.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_tb import dcache_pkg::*; ();
	logic clk;
	logic rst_b;
	dc_addr_u addr;
	logic rd_req;
	logic wr_req;
	logic [31:0] wr_data;
	logic bus_credit;
	dc_fill_beat_t fill;
	dc_side_rsp_t side_rsp;
	logic rw_wait;
	logic [31:0] rd_data;
	dc_bus_req_t bus_req;
	dc_side_req_t side_req;

	logic [31:0] pat_mem [0:255]; // kind, address, write data, expected per line.
	int n_pat;
	int cycle_limit;
	int cycles;
	logic [31:0] lfsr_state;
	logic [63:0] mem_model [logic [31:0]]; // sparse array of written words.

	// bus and sideband monitor state.
	int fill_count;
	int write_count;
	dc_bus_req_t last_fill;
	int side_count;
	logic [7:0] cur_delay; // peripheral delay of the running pattern.
	logic [7:0] side_delay;
	logic [23:0] side_reg;

	// memory and peripheral model state.
	int fill_served;
	int credit_returned;
	logic fill_busy;
	int fill_wait;
	int fill_beat;
	logic [31:0] fill_base;
	int credit_wait;
	int side_served;
	int side_cnt;
	logic side_active;

	dcache_top dcache_top_i (
		.clk, .rst_b, .addr, .rd_req, .wr_req, .wr_data, .bus_credit, .fill, .side_rsp,
		.rw_wait, .rd_data, .bus_req, .side_req
	);

	always #10 clk = ~clk;

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit.
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[6:0], fb};
		end
		return val;
	endfunction

	// default word is its byte address with the low half inverted.
	function automatic logic [63:0] mem_word(input logic [31:0] a);
		if (mem_model.exists(a))
			return mem_model[a];
		return {a, ~a};
	endfunction

	task automatic stop_run(input string what);
		$display("%s at %0t", what, $time);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_bus_req(input dc_bus_req_t got, input dc_bus_req_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "bus request mismatch");
		end
	endtask

	task automatic check_side_req(input dc_side_req_t got, input dc_side_req_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "sideband request mismatch");
		end
	endtask

	// samples requests mid-cycle where they are stable.
	always @(negedge clk) begin
		if (rst_b && bus_req.valid) begin
			if (bus_req.write) begin
				logic [31:0] a;
				logic [63:0] w;
				a = {1'b0, bus_req.addr};
				w = mem_word(a);
				for (int i = 0; i < 8; i++)
					if (bus_req.mask[i])
						w[8*i +: 8] = bus_req.data[8*i +: 8];
				mem_model[a] = w;
				write_count++;
			end else begin
				last_fill = bus_req;
				fill_count++;
			end
		end
		if (rst_b && side_req.valid) begin
			side_delay = cur_delay;
			side_reg = side_req.addr;
			side_count++;
		end
	end

	// memory model. line fills and credit returns.
	always @(posedge clk) begin
		if (rst_b) begin
			fill.valid <= 1'b0;
			bus_credit <= 1'b0;
			if (!fill_busy && fill_served != fill_count) begin
				fill_served++;
				fill_busy = 1'b1;
				fill_beat = 0;
				fill_base = {1'b0, last_fill.addr};
				fill_wait = int'(lfsr_bits(3)); // random start delay.
			end else if (fill_busy) begin
				if (fill_wait != 0) begin
					fill_wait--;
				end else begin
					fill.valid <= 1'b1;
					fill.did <= `DC_DID_CPU;
					fill.subdid <= `DC_SUBDID_DCACHE;
					fill.data <= mem_word(fill_base + 32'(8 * fill_beat));
					fill_beat++;
					if (fill_beat == `DC_BEATS)
						fill_busy = 1'b0;
				end
			end
			if (credit_wait != 0) begin
				credit_wait--;
			end else if (credit_returned != fill_count + write_count) begin
				bus_credit <= 1'b1;
				credit_returned++;
				credit_wait = int'(lfsr_bits(3));
			end
		end
	end

	// peripheral model. busy for the pattern delay and silent when it is 0.
	always @(posedge clk) begin
		if (rst_b) begin
			side_rsp.busy_b <= 1'b0;
			if (side_served != side_count) begin
				side_served = side_count;
				side_cnt = int'(side_delay);
				side_active = (side_delay != 8'd0);
			end
			if (side_active) begin
				if (side_cnt <= 1) begin
					side_rsp.busy_b <= 1'b1;
					side_rsp.data <= {8'ha5, side_reg};
					side_active = 1'b0;
				end else begin
					side_cnt--;
				end
			end
		end
	end

	// run limit.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic run_pattern(input int i);
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] exp;
		logic [31:0] got;
		int fills_before;
		logic first;
		logic done;
		dc_bus_req_t exp_bus;
		dc_side_req_t exp_side;
		op = pat_mem[4*i][7:0];
		a = pat_mem[4*i+1];
		wd = pat_mem[4*i+2];
		exp = pat_mem[4*i+3];
		cur_delay = pat_mem[4*i][15:8];
		fills_before = fill_count;
		@(posedge clk);
		addr <= a;
		rd_req <= (op == 8'd0) || (op == 8'd1) || (op == 8'd3);
		wr_req <= (op == 8'd2) || (op == 8'd4);
		wr_data <= wd;
		first = 1'b1;
		done = 1'b0;
		got = '0;
		while (!done) begin
			@(negedge clk);
			if (first && (op == 8'd3 || op == 8'd4)) begin
				exp_side = '{valid: 1'b1, r_nw: (op == 8'd3), did: a[27:24],
					addr: a[23:0], data: wd};
				check_side_req(side_req, exp_side, "sideband request");
			end
			if (first && op == 8'd0 && rw_wait)
				stop_run("read hit stalled the core");
			if (first && op == 8'd1 && !rw_wait)
				stop_run("read miss did not stall the core");
			if (!rw_wait) begin
				done = 1'b1;
				got = rd_data;
				if (op == 8'd2) begin
					exp_bus = '{valid: 1'b1, write: 1'b1, did: `DC_DID_CPU,
						subdid: `DC_SUBDID_DCACHE, addr: {a[30:3], 3'd0}, len: 4'd1,
						data: {wd, wd}, mask: a[2] ? 8'hf0 : 8'h0f};
					check_bus_req(bus_req, exp_bus, "write request");
				end
			end
			first = 1'b0;
		end
		@(posedge clk);
		rd_req <= 1'b0;
		wr_req <= 1'b0;
		if (op == 8'd0 || op == 8'd1 || op == 8'd3)
			check_data(got, exp, "read data");
		if (op == 8'd1) begin
			if (fill_count != fills_before + 1)
				stop_run("read miss did not issue exactly one fill");
			exp_bus = '{valid: 1'b1, write: 1'b0, did: `DC_DID_CPU,
				subdid: `DC_SUBDID_DCACHE, addr: {a[30:6], 6'd0}, len: 4'(`DC_BEATS),
				data: 64'd0, mask: 8'd0};
			check_bus_req(last_fill, exp_bus, "fill request");
		end
		if (op == 8'd0 && fill_count != fills_before)
			stop_run("read hit issued a fill");
	endtask

	initial begin
		clk = 1'b0;
		rst_b = 1'b0;
		addr = '0;
		rd_req = 1'b0;
		wr_req = 1'b0;
		wr_data = '0;
		bus_credit = 1'b0;
		fill = '0;
		side_rsp = '0;
		lfsr_state = 32'he30d9507;
		cycles = 0;
		fill_count = 0;
		write_count = 0;
		side_count = 0;
		fill_served = 0;
		credit_returned = 0;
		fill_busy = 1'b0;
		credit_wait = 0;
		side_served = 0;
		side_active = 1'b0;
		cur_delay = '0;
		side_delay = '0;
		for (int i = 0; i < 256; i++)
			pat_mem[i] = 32'hffffffff;
		$readmemh("bench/dcache_patterns.txt", pat_mem);
		n_pat = 0;
		while (n_pat < 64 && pat_mem[4*n_pat] != 32'hffffffff)
			n_pat++;
		cycle_limit = n_pat * 400;
		repeat (5) @(posedge clk);
		rst_b <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < n_pat; i++)
			run_pattern(i);
		$display("Result: PASSED");
		$finish;
	end
endmodule

// File: bench/dcache_assert.sv
// Bound checks for the data cache top level. Credit count is probed inside the bus request block.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_assert (
	input logic clk,
	input logic rst_b,
	input logic rw_wait,
	input logic bus_req_valid,
	input logic side_req_valid,
	input logic [`DC_CREDIT_W-1:0] credits
);
	// counter never climbs past the reset grant.
	credit_limit: assert property (@(posedge clk) disable iff (!rst_b)
		credits <= `DC_CREDIT_W'(`DC_BUS_CREDITS))
		else $error("credit count above the reset grant");

	// no request without a credit.
	credit_needed: assert property (@(posedge clk) disable iff (!rst_b)
		bus_req_valid |-> (credits != '0))
		else $error("bus request raised with zero credits");

	side_one_cycle: assert property (@(posedge clk) disable iff (!rst_b)
		side_req_valid |=> !side_req_valid)
		else $error("sideband request longer than one cycle");

	// quiet core port right out of reset.
	reset_quiet: assert property (@(posedge clk) $rose(rst_b) |-> !rw_wait)
		else $error("rw_wait high after reset release");
endmodule

bind dcache_top dcache_assert dcache_assert_i (
	.clk(clk),
	.rst_b(rst_b),
	.rw_wait(rw_wait),
	.bus_req_valid(bus_req.valid),
	.side_req_valid(side_req.valid),
	.credits(dcache_bus_req_i.credits)
);

// File: verilog/dcache_top.sv
// Write-through direct-mapped data cache. Address bit 31 routes the access to the sideband bus.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_top import dcache_pkg::*; (
	input  logic clk,
	input  logic rst_b,
	input  dc_addr_u addr,
	input  logic rd_req,
	input  logic wr_req,
	input  logic [31:0] wr_data,
	input  logic bus_credit,
	input  dc_fill_beat_t fill,
	input  dc_side_rsp_t side_rsp,
	output logic rw_wait,
	output logic [31:0] rd_data,
	output dc_bus_req_t bus_req,
	output dc_side_req_t side_req
);
	dc_state_e state;
	dc_timer_cmd_t timer_cmd;
	dc_addr_u fill_addr;
	logic fill_start, commit, side_start;
	logic hit, fill_beat_ok, credit_avail;
	logic timer_zero;
	logic [7:0] timer_count;
	logic [31:0] store_data;
	logic wr_fire; // write completes this cycle.

	assign wr_fire = wr_req && !rw_wait;

	dcache_ctrl dcache_ctrl_i (
		.clk, .rst_b, .addr, .rd_req, .wr_req, .hit, .credit_avail, .fill_beat_ok,
		.timer_zero, .side_busy_b(side_rsp.busy_b), .state, .timer_cmd,
		.fill_start, .commit, .side_start, .rw_wait, .fill_addr
	);

	dcache_timer dcache_timer_i (
		.clk, .rst_b, .cmd(timer_cmd), .count(timer_count), .zero(timer_zero)
	);

	dcache_store dcache_store_i (
		.clk, .rst_b, .addr, .wr_req(wr_fire), .wr_data, .fill,
		.fill_pos(timer_count[2:0]), .fill_start, .commit, .fill_addr,
		.hit, .rd_data(store_data), .fill_beat_ok
	);

	dcache_bus_req dcache_bus_req_i (
		.clk, .rst_b, .addr, .wr_req(wr_fire), .wr_data, .fill_start, .bus_credit,
		.bus_req, .credit_avail
	);

	// sideband request straight from the address word.
	always_comb begin
		side_req.valid = side_start;
		side_req.r_nw = rd_req;
		side_req.did = addr.side.did;
		side_req.addr = addr.side.reg_addr;
		side_req.data = wr_data;
	end

	// timeout wins only if the peripheral stayed busy.
	always_comb begin
		if (!addr.side.space)
			rd_data = store_data;
		else if ((state == st_side) && timer_zero && !side_rsp.busy_b)
			rd_data = `DC_SIDE_TIMEOUT_DATA;
		else
			rd_data = side_rsp.data;
	end
endmodule

// File: verilog/dcache_bus_req.sv
// Memory bus request formatting and credit count. Every request is one cycle, so one credit each.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_bus_req import dcache_pkg::*; (
	input  logic clk,
	input  logic rst_b,
	input  dc_addr_u addr,
	input  logic wr_req,
	input  logic [31:0] wr_data,
	input  logic fill_start,
	input  logic bus_credit,
	output dc_bus_req_t bus_req,
	output logic credit_avail
);
	logic [`DC_CREDIT_W-1:0] credits;

	assign credit_avail = (credits != '0);

	// returned credit and issued request may land together.
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			credits <= `DC_CREDIT_W'(`DC_BUS_CREDITS);
		else
			credits <= credits + `DC_CREDIT_W'(bus_credit) - `DC_CREDIT_W'(bus_req.valid);
	end

	always_comb begin
		bus_req = '0;
		bus_req.did = `DC_DID_CPU;
		bus_req.subdid = `DC_SUBDID_DCACHE;
		if (fill_start) begin
			// whole line. ctrl only starts with a credit.
			bus_req.valid = 1'b1;
			bus_req.write = 1'b0;
			bus_req.addr = {addr.mem.tag, addr.mem.index, 6'd0};
			bus_req.len = 4'(`DC_BEATS);
		end else if (wr_req && !addr.mem.space) begin
			// single beat with the word copied to both halves.
			bus_req.valid = 1'b1;
			bus_req.write = 1'b1;
			bus_req.addr = {addr.mem.tag, addr.mem.index, addr.mem.word, 3'd0};
			bus_req.len = 4'd1;
			bus_req.data = {wr_data, wr_data};
			bus_req.mask = addr.mem.half ? 8'hf0 : 8'h0f; // mask picks the half.
		end
	end
endmodule

// File: verilog/dcache_store.sv
// Tag and data arrays of the direct-mapped cache. Reads are combinational, so a hit costs no cycle.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_store import dcache_pkg::*; (
	input  logic clk,
	input  logic rst_b,
	input  dc_addr_u addr,
	input  logic wr_req,
	input  logic [31:0] wr_data,
	input  dc_fill_beat_t fill,
	input  logic [2:0] fill_pos,
	input  logic fill_start,
	input  logic commit,
	input  dc_addr_u fill_addr,
	output logic hit,
	output logic [31:0] rd_data,
	output logic fill_beat_ok
);
	logic [`DC_LINES-1:0] line_valid;
	logic [`DC_TAG_W-1:0] tags [`DC_LINES];
	logic [31:0] data_hi [`DC_LINES][`DC_BEATS]; // byte offsets 4 to 7.
	logic [31:0] data_lo [`DC_LINES][`DC_BEATS]; // byte offsets 0 to 3.
	logic filling; // beats are expected.
	logic [`DC_TAG_W-1:0] req_tag;
	logic [`DC_TAG_W-1:0] fill_tag;
	logic [3:0] idx;
	logic [3:0] fill_idx;

	assign idx = addr.mem.index;
	assign fill_idx = fill_addr.mem.index;

	// space bit in the tag keeps sideband addresses from hitting.
	assign req_tag = {addr.mem.space, addr.mem.tag};
	assign fill_tag = {fill_addr.mem.space, fill_addr.mem.tag};

	assign hit = line_valid[idx] && (tags[idx] == req_tag);
	assign rd_data = addr.mem.half ? data_hi[idx][addr.mem.word] : data_lo[idx][addr.mem.word];

	// only our own beats, and only while a fill is open.
	assign fill_beat_ok = filling && fill.valid &&
		(fill.did == `DC_DID_CPU) && (fill.subdid == `DC_SUBDID_DCACHE);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			line_valid <= '0;
			filling <= 1'b0;
		end else if (fill_start) begin
			line_valid[idx] <= 1'b0; // old contents dropped now.
			filling <= 1'b1;
		end else if (commit) begin
			line_valid[fill_idx] <= 1'b1;
			filling <= 1'b0;
		end
	end

	// tag written once the whole line is in.
	always_ff @(posedge clk) begin
		if (commit)
			tags[fill_idx] <= fill_tag;
	end

	always_ff @(posedge clk) begin
		if (fill_beat_ok) begin
			data_hi[fill_idx][fill_pos] <= fill.data[63:32];
			data_lo[fill_idx][fill_pos] <= fill.data[31:0];
		end
		// write-through. memory gets it from the bus block.
		if (wr_req && hit && addr.mem.half)
			data_hi[idx][addr.mem.word] <= wr_data;
		if (wr_req && hit && !addr.mem.half)
			data_lo[idx][addr.mem.word] <= wr_data;
	end
endmodule

// File: verilog/dcache_timer.sv
// Shared counter for fill beat position and sideband timeout. The two uses never overlap.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_timer import dcache_pkg::*; (
	input  logic clk,
	input  logic rst_b,
	input  dc_timer_cmd_t cmd,
	output logic [7:0] count,
	output logic zero
);
	logic fill_mode; // 1 counts beats up.

	// terminal flag.
	// last beat position in fill mode, expired in timeout mode.
	assign zero = fill_mode ? (count == 8'(`DC_BEATS - 1)) : (count == 8'd0);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			count <= 8'd0;
			fill_mode <= 1'b0;
		end else if (cmd.load_beats) begin
			count <= 8'd0; // first beat is word 0.
			fill_mode <= 1'b1;
		end else if (cmd.load_timeout) begin
			count <= 8'(`DC_SIDE_TIMEOUT);
			fill_mode <= 1'b0;
		end else if (cmd.step) begin
			if (fill_mode)
				count <= count + 8'd1;
			else if (count != 8'd0)
				count <= count - 8'd1; // holds at zero.
		end
	end
endmodule

// File: verilog/dcache_ctrl.sv
// Cache control FSM. One fill or sideband access at a time. The core must hold its request while rw_wait is high.
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*; (
	input  logic clk,
	input  logic rst_b,
	input  dc_addr_u addr,
	input  logic rd_req,
	input  logic wr_req,
	input  logic hit,
	input  logic credit_avail,
	input  logic fill_beat_ok,
	input  logic timer_zero,
	input  logic side_busy_b,
	output dc_state_e state,
	output dc_timer_cmd_t timer_cmd,
	output logic fill_start,
	output logic commit,
	output logic side_start,
	output logic rw_wait,
	output dc_addr_u fill_addr
);
	dc_state_e state_next;
	logic cached;
	logic any_req;
	logic fill_line;
	logic side_done;

	assign cached = !addr.mem.space;
	assign any_req = rd_req || wr_req;

	// request falls in the line being filled.
	assign fill_line = (addr.mem.space == fill_addr.mem.space) &&
		(addr.mem.tag == fill_addr.mem.tag) &&
		(addr.mem.index == fill_addr.mem.index);

	// peripheral answered or gave up waiting.
	assign side_done = side_busy_b || timer_zero;

	// misses wait in idle until a credit shows up.
	assign fill_start = (state == st_idle) && rd_req && cached && !hit && credit_avail;
	assign side_start = (state == st_idle) && any_req && !cached; // one-cycle request.
	assign commit = (state == st_commit);

	assign timer_cmd.load_beats = fill_start;
	assign timer_cmd.load_timeout = side_start;
	// beat position moves per accepted beat, timeout per cycle.
	assign timer_cmd.step = ((state == st_fill) && fill_beat_ok) || (state == st_side);

	always_comb begin
		state_next = state;
		rw_wait = 1'b0;
		case (state)
			st_idle: begin
				if (side_start) begin
					state_next = st_side;
					rw_wait = 1'b1;
				end else if (rd_req && !hit) begin
					rw_wait = 1'b1; // miss stalls until commit.
					if (credit_avail)
						state_next = st_fill;
				end else if (wr_req && !credit_avail) begin
					rw_wait = 1'b1; // no credit for the write.
				end
			end
			st_fill: begin
				// writes elsewhere may still go out.
				rw_wait = rd_req || (wr_req && (fill_line || !cached || !credit_avail));
				if (fill_beat_ok && timer_zero)
					state_next = st_commit; // last beat.
			end
			st_commit: begin
				rw_wait = rd_req || (wr_req && (fill_line || !cached || !credit_avail));
				state_next = st_idle; // line valid next cycle.
			end
			st_side: begin
				rw_wait = !side_done;
				if (side_done)
					state_next = st_idle;
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b)
			state <= st_idle;
		else
			state <= state_next;
	end

	// line address of the fill in flight.
	always_ff @(posedge clk) begin
		if (fill_start)
			fill_addr <= {addr[31:6], 6'd0}; // frozen until the next miss.
	end
endmodule

// File: verilog/dcache_pkg.sv
// Shared types for the data cache. The cached address view assumes 16 lines of 64 bytes.
package dcache_pkg;
	`include "dcache_defs.svh"

	// cached view of a core address.
	typedef struct packed {
		logic space; // 0 for memory.
		logic [`DC_TAG_W-2:0] tag; // bits 30 to 10.
		logic [3:0] index; // line select.
		logic [2:0] word; // 64-bit word in line.
		logic half; // 1 picks the high half.
		logic [1:0] offset; // ignored byte select.
	} dc_mem_addr_t;

	// sideband view of the same word.
	typedef struct packed {
		logic space; // 1 for peripherals.
		logic [2:0] unused;
		logic [3:0] did; // target peripheral.
		logic [23:0] reg_addr;
	} dc_side_addr_t;

	// one address word decoded by its space bit.
	typedef union packed {
		dc_mem_addr_t mem;
		dc_side_addr_t side;
	} dc_addr_u;

	// outbound memory bus request.
	typedef struct packed {
		logic valid;
		logic write; // 0 is a line fill.
		logic [3:0] did;
		logic [3:0] subdid;
		logic [30:0] addr; // 64-bit aligned byte address.
		logic [3:0] len; // beats.
		logic [63:0] data;
		logic [7:0] mask; // byte enables.
	} dc_bus_req_t;

	// inbound fill beat.
	typedef struct packed {
		logic valid;
		logic [3:0] did;
		logic [3:0] subdid;
		logic [63:0] data;
	} dc_fill_beat_t;

	// sideband request and response.
	typedef struct packed {
		logic valid;
		logic r_nw; // 1 for a read.
		logic [3:0] did;
		logic [23:0] addr;
		logic [31:0] data;
	} dc_side_req_t;

	typedef struct packed {
		logic busy_b; // high ends the access.
		logic [31:0] data;
	} dc_side_rsp_t;

	typedef enum logic [1:0] {
		st_idle,
		st_fill,
		st_commit,
		st_side
	} dc_state_e;

	// controls for the shared counter.
	typedef struct packed {
		logic load_beats; // start fill position at 0.
		logic load_timeout; // start sideband timeout.
		logic step;
	} dc_timer_cmd_t;
endpackage

// File: verilog/dcache_defs.svh
// Geometry and bus ids for the data cache. Changing DC_BEATS or DC_LINES also needs the address union resized.
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry.
`define DC_LINES 16 // lines in the cache.
`define DC_BEATS 8 // 64-bit words per line.

// stored tag covers address bits 31 to 10 with the space bit.
`define DC_TAG_W 22

// memory bus flow control.
`define DC_BUS_CREDITS 4 // credits granted at reset.
`define DC_CREDIT_W 3 // must hold DC_BUS_CREDITS.

// sideband access limits.
`define DC_SIDE_TIMEOUT 255 // cycles before giving up.
`define DC_SIDE_TIMEOUT_DATA 32'hdeaddead // read data on timeout.

// ids this cache uses on the memory bus.
`define DC_DID_CPU 4'h0
`define DC_SUBDID_DCACHE 4'h1

`endif
